/* logic/sdram_pkg.sv */
/*
 * SDRAM port shared definitions.
 * Word and address widths, the bank/row/column split, command codes,
 * the internal request bundle, the pin bundle and the controller states.
 */
package sdram_pkg;

   typedef logic [15:0] word_t;        // one memory word
   typedef logic [1:0]  byte_sel_t;    // bit 1 is the high byte
   typedef logic [20:0] word_addr_t;   // word address from the bus
   typedef logic [8:0]  col_t;         // low bits of word address
   typedef logic [1:0]  bank_t;        // next two bits
   typedef logic [9:0]  row_t;         // top bits, zero extended on the pins
   typedef logic [12:0] pin_addr_t;    // address pin bus

   // ras_n, cas_n, we_n
   localparam logic [2:0] CMD_NOP   = 3'b111;
   localparam logic [2:0] CMD_ACT   = 3'b011;
   localparam logic [2:0] CMD_READ  = 3'b101;
   localparam logic [2:0] CMD_WRITE = 3'b100;
   localparam logic [2:0] CMD_PRE   = 3'b010;
   localparam logic [2:0] CMD_REF   = 3'b001;
   localparam logic [2:0] CMD_MRS   = 3'b000;

   localparam pin_addr_t MODE_WORD = 13'b000_0_00_010_0_000; // bl 1, sequential, cl 2

   typedef struct packed {
      logic       write;   // 1 = write
      byte_sel_t  dqm;     // 1 masks a byte
      word_addr_t addr;
      word_t      data;
   } mem_req_t;

   typedef struct packed {
      logic      cke;
      logic      cs_n;
      logic      ras_n;
      logic      cas_n;
      logic      we_n;
      bank_t     ba;
      pin_addr_t addr;
      byte_sel_t dqm;
   } sdram_pins_t;

   typedef enum logic [3:0] {
      init_wait, init_precharge, init_refresh, init_mode,
      idle, refresh,
      activate, rcd_wait,
      rd_cmd, cas_wait, wr_cmd,
      done
   } ctrl_state_t;

   function automatic col_t addr_col(input word_addr_t a);
      return a[8:0];
   endfunction

   function automatic bank_t addr_bank(input word_addr_t a);
      return a[10:9];
   endfunction

   function automatic row_t addr_row(input word_addr_t a);
      return a[20:11];
   endfunction

endpackage

/* logic/sdram_reset_gen.sv */
/*
 * SDRAM reset stretcher.
 * Syncs the system reset and keeps the memory controller in reset
 * for a few more cycles once the system reset is gone.
 */
`timescale 1ns/1ns

module sdram_reset_gen (
   input  logic clk_p,
   input  logic sdram_reset,   // system reset, active high
   output logic ctrl_rst       // controller reset, active high
);

   logic [1:0] rst_sync;       // two flop synchronizer
   logic [1:0] dly_cnt;        // release delay

   always_ff @(posedge clk_p) begin
      rst_sync <= {rst_sync[0], sdram_reset};
      if (rst_sync[1]) begin
         ctrl_rst <= 1'b1;     // hold controller
         dly_cnt  <= 2'd0;     // restart delay
      end else if (dly_cnt != 2'd3) begin
         dly_cnt  <= dly_cnt + 2'd1;
      end else begin
         ctrl_rst <= 1'b0;     // delay over, let it run
      end
   end

endmodule

/* logic/sdram_bus_bridge.sv */
/*
 * SDRAM bus bridge.
 * Turns one strobe-held bus transaction into one request strobe,
 * forms the byte mask and holds ack while stb stays high.
 */
`timescale 1ns/1ns

module sdram_bus_bridge import sdram_pkg::*; (
   input  logic       clk_p,
   input  logic       sdram_reset,
   // system bus
   input  logic       stb,        // held until ack
   input  logic       we,
   input  byte_sel_t  sel,
   input  word_addr_t adr,
   input  word_t      dat_w,
   output logic       ack,
   output word_t      dat_r,
   // controller side
   output logic       req_stb,    // one cycle per transaction
   output mem_req_t   req,
   input  logic       done_stb,
   input  word_t      rd_data
);

   logic served;                  // request already sent for this stb
   logic reply;                   // controller finished, ack pending
   logic issue;                   // first cycle of a new transaction

   assign issue = stb & ~served;

   //**************************************************************************
   //* request and reply flags
   //**************************************************************************
   always_ff @(posedge clk_p) begin
      if (sdram_reset) begin
         served  <= 1'b0;
         reply   <= 1'b0;
         req_stb <= 1'b0;
      end else begin
         req_stb <= issue;                // single pulse
         if (!stb)
            served <= 1'b0;               // transaction over
         else if (issue)
            served <= 1'b1;
         if (stb && done_stb)
            reply <= 1'b1;                // ack from next cycle
         else if (!stb)
            reply <= 1'b0;                // master dropped stb
      end
   end

   //**************************************************************************
   //* request payload and read data
   //**************************************************************************
   always_ff @(posedge clk_p) begin
      if (issue) begin
         req.write <= we;
         req.dqm   <= we ? ~sel : 2'b00;  // reads always whole word
         req.addr  <= adr;
         req.data  <= dat_w;
      end
      if (done_stb)
         dat_r <= rd_data;                // held until next reply
   end

   // falls with stb, no extra cycle
   assign ack = stb & reply;

endmodule

/* logic/sdram_ctrl.sv */
/*
 * SDRAM controller.
 * Power-up sequence, periodic auto refresh and single-word read and
 * write with auto-precharge, CAS latency 2.
 */
`timescale 1ns/1ns

module sdram_ctrl import sdram_pkg::*; #(
   parameter int INIT_WAIT      = 200,   // power-up idle, cycles
   parameter int REFRESH_PERIOD = 150    // cycles between refreshes
) (
   input  logic        clk_p,
   input  logic        ctrl_rst,
   input  logic        req_stb,
   input  mem_req_t    req,
   output logic        done_stb,
   output word_t       rd_data,
   output logic        init_done,
   output sdram_pins_t pins,
   inout  wire word_t  dq
);

   localparam int T_RP  = 2;   // precharge to refresh
   localparam int T_RFC = 8;   // refresh cycle
   localparam int T_MRD = 2;   // mode set to first command
   localparam int T_CAS = 2;   // read latency, also write recovery

   ctrl_state_t state;
   logic [15:0] timer;          // per-state cycle count
   logic [15:0] ref_cnt;        // cycles since last refresh
   logic        ref_second;     // second init refresh issued
   logic        ref_due;
   logic        start;          // open a row this cycle
   logic        hold_req;       // req_stb goes into pending slot
   logic        pend_valid;
   mem_req_t    pend;           // one-entry pending request
   mem_req_t    cur;            // request being served
   mem_req_t    next_req;
   pin_addr_t   act_addr;       // row on the pins
   pin_addr_t   cas_addr;       // column with a10 set for auto-precharge
   logic        dq_oe;

   // pins for one command, chip enabled and selected
   function automatic sdram_pins_t cmd_pins(input logic [2:0] cmd,
                                            input bank_t      ba,
                                            input pin_addr_t  addr,
                                            input byte_sel_t  dqm);
      sdram_pins_t p;
      p.cke  = 1'b1;
      p.cs_n = 1'b0;
      {p.ras_n, p.cas_n, p.we_n} = cmd;
      p.ba   = ba;
      p.addr = addr;
      p.dqm  = dqm;
      return p;
   endfunction

   assign ref_due  = ref_cnt >= REFRESH_PERIOD;
   assign next_req = pend_valid ? pend : req;      // stored one goes first
   assign start    = (state == idle) && !ref_due && (req_stb || pend_valid);
   assign hold_req = req_stb && !(start && !pend_valid);

   assign act_addr = {3'b000, addr_row(next_req.addr)};
   assign cas_addr = {2'b00, 1'b1, 1'b0, addr_col(cur.addr)};

   // driven only during the write command cycle
   assign dq = dq_oe ? cur.data : 'z;

   //**************************************************************************
   //* state machine and command pins
   //**************************************************************************
   always_ff @(posedge clk_p) begin
      if (ctrl_rst) begin
         state      <= init_wait;
         timer      <= '0;
         ref_cnt    <= '0;
         ref_second <= 1'b0;
         pend_valid <= 1'b0;
         init_done  <= 1'b0;
         done_stb   <= 1'b0;
         dq_oe      <= 1'b0;
         pins       <= '{cke: 1'b0, cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1,
                         we_n: 1'b1, ba: '0, addr: '0, dqm: 2'b11};
      end else begin
         // defaults, nop and no strobe
         pins     <= cmd_pins(CMD_NOP, '0, '0, 2'b11);
         done_stb <= 1'b0;
         dq_oe    <= 1'b0;
         timer    <= timer + 16'd1;
         if (init_done)
            ref_cnt <= ref_cnt + 16'd1;

         if (hold_req)
            pend_valid <= 1'b1;      // busy, keep it for later
         else if (start)
            pend_valid <= 1'b0;      // slot consumed

         case (state)
            init_wait: begin
               if (timer == INIT_WAIT - 1) begin
                  pins  <= cmd_pins(CMD_PRE, '0, 13'h0400, 2'b11); // a10, all banks
                  timer <= '0;
                  state <= init_precharge;
               end
            end
            init_precharge: begin
               if (timer == T_RP - 1) begin
                  pins  <= cmd_pins(CMD_REF, '0, '0, 2'b11);
                  timer <= '0;
                  state <= init_refresh;
               end
            end
            init_refresh: begin
               if (timer == T_RFC - 1) begin
                  timer <= '0;
                  if (ref_second) begin
                     pins  <= cmd_pins(CMD_MRS, '0, MODE_WORD, 2'b11);
                     state <= init_mode;
                  end else begin
                     pins       <= cmd_pins(CMD_REF, '0, '0, 2'b11); // second one
                     ref_second <= 1'b1;
                  end
               end
            end
            init_mode: begin
               if (timer == T_MRD - 1) begin
                  init_done <= 1'b1;             // stays until next reset
                  ref_cnt   <= '0;
                  state     <= idle;
               end
            end
            idle: begin
               if (ref_due) begin                // refresh wins
                  pins    <= cmd_pins(CMD_REF, '0, '0, 2'b11);
                  ref_cnt <= '0;
                  timer   <= '0;
                  state   <= refresh;
               end else if (start) begin
                  pins  <= cmd_pins(CMD_ACT, addr_bank(next_req.addr), act_addr, 2'b11);
                  state <= activate;
               end
            end
            refresh: begin
               if (timer == T_RFC - 1)
                  state <= idle;
            end
            activate: state <= rcd_wait;         // act on pins, trcd 1 of 2
            rcd_wait: begin
               timer <= '0;
               if (cur.write) begin
                  pins  <= cmd_pins(CMD_WRITE, addr_bank(cur.addr), cas_addr, cur.dqm);
                  dq_oe <= 1'b1;                 // data with the command
                  state <= wr_cmd;
               end else begin
                  pins  <= cmd_pins(CMD_READ, addr_bank(cur.addr), cas_addr, 2'b00);
                  state <= rd_cmd;
               end
            end
            rd_cmd, wr_cmd: begin
               timer <= '0;
               state <= cas_wait;
            end
            cas_wait: begin
               if (timer == T_CAS - 1) begin     // read data sampled on this edge
                  done_stb <= 1'b1;
                  state    <= done;
               end
            end
            done:    state <= idle;
            default: state <= idle;
         endcase
      end
   end

   //**************************************************************************
   //* request and read data registers
   //**************************************************************************
   always_ff @(posedge clk_p) begin
      if (hold_req)
         pend <= req;
      if (start)
         cur <= next_req;                        // bank, row, col come from here
      if (state == cas_wait && timer == T_CAS - 1 && !cur.write)
         rd_data <= dq;                          // cl 2 after the read command
   end

endmodule

/* logic/sdram_port.sv */
/*
 * SDRAM port top level.
 * Reset stretcher, bus bridge and memory controller wired together.
 */
`timescale 1ns/1ns

module sdram_port import sdram_pkg::*; #(
   parameter int INIT_WAIT      = 200,
   parameter int REFRESH_PERIOD = 150
) (
   input  logic        clk_p,
   input  logic        sdram_reset,
   // system bus
   input  logic        stb,
   input  logic        we,
   input  byte_sel_t   sel,
   input  word_addr_t  adr,
   input  word_t       dat_w,
   output logic        ack,
   output word_t       dat_r,
   output logic        ready,       // memory initialized
   // memory pins
   output sdram_pins_t pins,
   inout  wire word_t  dq
);

   logic     ctrl_rst;
   logic     req_stb;
   logic     done_stb;
   mem_req_t req;
   word_t    rd_data;

   sdram_reset_gen sdram_reset_gen_i (
      .clk_p       (clk_p),
      .sdram_reset (sdram_reset),
      .ctrl_rst    (ctrl_rst)
   );

   sdram_bus_bridge sdram_bus_bridge_i (
      .clk_p       (clk_p),
      .sdram_reset (sdram_reset),
      .stb         (stb),
      .we          (we),
      .sel         (sel),
      .adr         (adr),
      .dat_w       (dat_w),
      .ack         (ack),
      .dat_r       (dat_r),
      .req_stb     (req_stb),
      .req         (req),
      .done_stb    (done_stb),
      .rd_data     (rd_data)
   );

   sdram_ctrl #(
      .INIT_WAIT      (INIT_WAIT),
      .REFRESH_PERIOD (REFRESH_PERIOD)
   ) sdram_ctrl_i (
      .clk_p     (clk_p),
      .ctrl_rst  (ctrl_rst),
      .req_stb   (req_stb),
      .req       (req),
      .done_stb  (done_stb),
      .rd_data   (rd_data),
      .init_done (ready),           // ready is init done
      .pins      (pins),
      .dq        (dq)
   );

endmodule

/* sim/tb_clock.sv */
/*
 * Testbench clock source.
 * Free-running clk_p, 4 ns period.
 */
`timescale 1ns/1ns

module tb_clock #(
   parameter int HALF_PERIOD = 2     // ns
) (
   output logic clk_p
);

   initial begin
      clk_p = 1'b0;                  // first rising edge at 2 ns
      forever begin
         #HALF_PERIOD clk_p = ~clk_p;
      end
   end

endmodule

/* sim/sdram_model.sv */
/*
 * Behavioral SDRAM memory.
 * Decodes ACT, READ and WRITE from the pin bundle, keeps words in sparse
 * storage and returns read data with CAS latency 2. Contents survive reset.
 */
`timescale 1ns/1ns

module sdram_model import sdram_pkg::*; (
   input  logic        clk_p,
   input  sdram_pins_t pins,
   inout  wire word_t  dq
);

   word_t      mem [word_addr_t];   // only written words exist
   row_t       open_row [4];        // row latched per bank on ACT
   logic [1:0] rd_vld = 2'b00;      // read pipe, stage 1 drives dq
   word_t      rd_word [2];
   logic [2:0] cmd;
   word_addr_t key;                 // same split as the bus word address
   word_t      old;

   assign cmd = {pins.ras_n, pins.cas_n, pins.we_n};
   assign key = {open_row[pins.ba], pins.ba, pins.addr[8:0]};

   // data valid across the second edge after the read command
   assign dq = rd_vld[1] ? rd_word[1] : 'z;

   always @(posedge clk_p) begin
      rd_vld[1]  <= rd_vld[0];
      rd_word[1] <= rd_word[0];
      rd_vld[0]  <= 1'b0;
      if (pins.cke === 1'b1 && pins.cs_n === 1'b0) begin
         case (cmd)
            CMD_ACT: open_row[pins.ba] <= pins.addr[9:0];
            CMD_READ: begin
               rd_vld[0]  <= 1'b1;
               rd_word[0] <= mem.exists(key) ? mem[key] : 16'h0000; // unwritten reads zero
            end
            CMD_WRITE: begin
               old = mem.exists(key) ? mem[key] : 16'h0000;
               mem[key] = {pins.dqm[1] ? old[15:8] : dq[15:8],  // dqm 1 keeps old byte
                           pins.dqm[0] ? old[7:0]  : dq[7:0]};
            end
            default: ;                                         // nop, pre, ref, mrs
         endcase
      end
   end

endmodule

/* sim/sdram_checker.sv */
/*
 * Testbench checker.
 * Watches ack, ready and read data, compares reads against the expected
 * word from the stimulus, counts errors and prints the closing line.
 */
`timescale 1ns/1ns

module sdram_checker import sdram_pkg::*; (
   input  logic  clk_p,
   input  logic  sdram_reset,
   input  logic  ack,
   input  logic  ready,
   input  word_t dat_r,
   input  logic  exp_check,        // current transaction is a read
   input  word_t exp_data
);

   int   ack_count     = 0;        // one per transaction expected
   int   mismatch_errs = 0;
   int   protocol_errs = 0;
   int   rst_run       = 0;        // cycles reset has been high
   logic ack_q         = 1'b0;

   //**************************************************************************
   //* per-cycle checks
   //**************************************************************************
   always @(posedge clk_p) begin
      ack_q   <= (ack === 1'b1);
      rst_run <= (sdram_reset === 1'b1) ? rst_run + 1 : 0;
      if (ack === 1'b1 && !ack_q) begin              // new ack cycle
         ack_count++;
         if (ready !== 1'b1) begin
            $display("ERROR at %0t: ack seen while ready is low", $time);
            protocol_errs++;
         end
         if (exp_check && dat_r !== exp_data) begin
            $display("FAILED @%0t: read data %h, expected %h", $time, dat_r, exp_data);
            mismatch_errs++;
         end
      end
      if (rst_run == 5 && ready === 1'b1) begin      // ready should be low by now
         $display("ERROR at %0t: ready stayed high during reset", $time);
         protocol_errs++;
      end
   end

   // closing line, returns all errors together
   task automatic report_totals(input int n_trans, input int timeouts,
                                input int assert_errs, input int tb_errs,
                                output int total);
      if (ack_count != n_trans) begin
         $display("ERROR: %0d acks seen for %0d bus transactions", ack_count, n_trans);
         protocol_errs++;
      end
      total = mismatch_errs + protocol_errs + timeouts + assert_errs + tb_errs;
      $display("errors: %0d data, %0d protocol, %0d timeout, %0d assertion, %0d other",
               mismatch_errs, protocol_errs, timeouts, assert_errs, tb_errs);
   endtask

endmodule

/* sim/sdram_port_assertions.sv */
/*
 * SDRAM port protocol assertions, bound into sdram_port.
 */
`timescale 1ns/1ns

module sdram_port_assertions import sdram_pkg::*; (
   input logic        clk_p,
   input logic        sdram_reset,
   input logic        stb,
   input logic        ack,
   input logic        ready,
   input sdram_pins_t pins,
   input word_t       dq,          // resolved data bus
   input logic        dq_oe        // controller drives dq
);

   int   assert_errs = 0;          // failed assertion count
   logic rd_or_wr;

   assign rd_or_wr = !pins.cs_n && pins.ras_n && !pins.cas_n;   // READ or WRITE

   // no stale reply, stb must have been held since the cycle before
   a_ack_in_stb: assert property (@(posedge clk_p) ack |-> stb && $past(stb))
      else begin
         $error("ack high without stb held");
         assert_errs++;
      end

   a_ready_holds: assert property (@(posedge clk_p) $fell(ready) |-> sdram_reset)
      else begin
         $error("ready fell outside reset");
         assert_errs++;
      end

   a_cmd_after_ready: assert property (@(posedge clk_p) rd_or_wr |-> ready)
      else begin
         $error("read or write command before ready");
         assert_errs++;
      end

   // no bus fight with the memory while the controller drives
   a_dq_write_only: assert property (@(posedge clk_p)
      dq_oe |-> (!pins.cs_n && {pins.ras_n, pins.cas_n, pins.we_n} == CMD_WRITE
                 && !$isunknown(dq)))
      else begin
         $error("dq driven outside write command or with unknown data");
         assert_errs++;
      end

endmodule

bind sdram_port sdram_port_assertions assertions_i (
   .clk_p       (clk_p),
   .sdram_reset (sdram_reset),
   .stb         (stb),
   .ack         (ack),
   .ready       (ready),
   .pins        (pins),
   .dq          (dq),
   .dq_oe       (sdram_ctrl_i.dq_oe)
);

/* sim/sdram_port_tb.sv */
/*
 * SDRAM port testbench top.
 * Reads bus operations from the cases file and drives the strobe-held
 * bus on the falling edge, one transaction at a time.
 */
`timescale 1ns/1ns

module sdram_port_tb import sdram_pkg::*; ();

   localparam int WAIT_LIMIT = 2000;   // cycles per wait

   logic        clk_p;
   logic        sdram_reset;
   logic        stb, we, ack, ready;
   byte_sel_t   sel;
   word_addr_t  adr;
   word_t       dat_w, dat_r, exp_data;
   logic        exp_check;
   sdram_pins_t pins;
   wire word_t  dq;
   int          n_trans, timeout_errs, tb_errs;
   logic        aborted;

   tb_clock clock_i (.clk_p(clk_p));

   sdram_port #(
      .INIT_WAIT      (200),
      .REFRESH_PERIOD (150)
   ) sdram_port_i (
      .clk_p (clk_p), .sdram_reset (sdram_reset),
      .stb   (stb),   .we    (we),    .sel   (sel),   .adr (adr), .dat_w (dat_w),
      .ack   (ack),   .dat_r (dat_r), .ready (ready),
      .pins  (pins),  .dq    (dq)
   );

   sdram_model model_i (.clk_p(clk_p), .pins(pins), .dq(dq));

   sdram_checker checker_i (
      .clk_p (clk_p), .sdram_reset (sdram_reset), .ack (ack), .ready (ready),
      .dat_r (dat_r), .exp_check (exp_check), .exp_data (exp_data)
   );

   task automatic wait_ready();
      int n;
      n = 0;
      while (ready !== 1'b1 && n < WAIT_LIMIT) begin
         @(negedge clk_p);
         n++;
      end
      if (ready !== 1'b1) begin
         $display("ERROR at %0t: ready did not rise within %0d cycles", $time, WAIT_LIMIT);
         timeout_errs++;
         aborted = 1'b1;
      end
   endtask

   // reset for 16 cycles, then wait for the memory to come up
   task automatic pulse_reset();
      sdram_reset = 1'b1;
      repeat (16) @(negedge clk_p);
      sdram_reset = 1'b0;
      wait_ready();
   endtask

   task automatic bus_cycle(input logic wr, input byte_sel_t s, input word_addr_t a,
                            input word_t d, input logic chk, input word_t e);
      int n;
      @(negedge clk_p);                         // cycle after the last ack fell
      stb       = 1'b1;
      we        = wr;
      sel       = s;
      adr       = a;
      dat_w     = d;
      exp_check = chk;
      exp_data  = e;
      n = 0;
      do begin
         @(posedge clk_p);                      // ack sampled before the edge
         n++;
      end while (ack !== 1'b1 && n < WAIT_LIMIT);
      if (ack !== 1'b1) begin
         $display("ERROR at %0t: no ack within %0d cycles for address %h", $time, WAIT_LIMIT, a);
         timeout_errs++;
         aborted = 1'b1;
      end
      @(negedge clk_p);
      stb       = 1'b0;                         // ack drops with it
      we        = 1'b0;
      exp_check = 1'b0;
      n_trans++;
   endtask

   //**************************************************************************
   //* stimulus from the cases file
   //**************************************************************************
   initial begin
      int         fd, nf, total;
      string      line;
      logic [7:0] op;
      logic [31:0] f1, f2, f3;
      stb          = 1'b0;
      we           = 1'b0;
      sel          = '0;
      adr          = '0;
      dat_w        = '0;
      exp_check    = 1'b0;
      exp_data     = '0;
      sdram_reset  = 1'b1;
      n_trans      = 0;
      timeout_errs = 0;
      tb_errs      = 0;
      aborted      = 1'b0;
      pulse_reset();
      fd = $fopen("sim/sdram_cases.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open sim/sdram_cases.txt");
         tb_errs++;
         aborted = 1'b1;
      end
      while (!aborted && !$feof(fd)) begin
         line = "";
         nf = $fgets(line, fd);
         if (nf == 0 || line.len() < 1 || line[0] == "#" || line[0] == "\n")
            continue;                           // blank or comment
         nf = $sscanf(line, "%c %h %h %h", op, f1, f2, f3);
         case (op)
            "W": bus_cycle(1'b1, f2[1:0], f1[20:0], f3[15:0], 1'b0, '0);
            "R": bus_cycle(1'b0, 2'b11, f1[20:0], '0, 1'b1, f2[15:0]);
            "I": repeat (f1) @(negedge clk_p);
            "X": pulse_reset();
            default: begin
               $display("ERROR: unknown opcode in cases line: %s", line);
               tb_errs++;
            end
         endcase
      end
      if (fd != 0)
         $fclose(fd);
      repeat (4) @(negedge clk_p);
      checker_i.report_totals(n_trans, timeout_errs, sdram_port_i.assertions_i.assert_errs,
                              tb_errs, total);
      if (total == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* sim/sdram_cases.txt */
# W addr sel data | R addr expected | I idle_cycles | X reset pulse
# all numbers hex, addr is the 21-bit word address {row, bank, col}
W 000010 3 a5c3
R 000010 a5c3
W 000020 1 1111
W 000020 2 2222
R 000020 2211
R 000030 0000
W 000205 3 1b1b
I 0c8
W 001c44 3 2c2c
I 0c8
W 1ffdff 3 3d3d
I 0c8
R 000205 1b1b
R 001c44 2c2c
R 1ffdff 3d3d
X
R 000010 a5c3
R 000020 2211
W 000011 3 0f0f
R 000011 0f0f

/* sources.f */
logic/sdram_pkg.sv
logic/sdram_reset_gen.sv
logic/sdram_bus_bridge.sv
logic/sdram_ctrl.sv
logic/sdram_port.sv
sim/tb_clock.sv
sim/sdram_model.sv
sim/sdram_checker.sv
sim/sdram_port_assertions.sv
sim/sdram_port_tb.sv

/* Bender.yml */
package:
  name: sdram_port

sources:
  - logic/sdram_pkg.sv
  - logic/sdram_reset_gen.sv
  - logic/sdram_bus_bridge.sv
  - logic/sdram_ctrl.sv
  - logic/sdram_port.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/sdram_model.sv
      - sim/sdram_checker.sv
      - sim/sdram_port_assertions.sv
      - sim/sdram_port_tb.sv
